// File: source/video_config.svh
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

//==============================
// 640 x 400 at 70 Hz
//==============================

// Horizontal timing in clocks
`define VIDEO_HLINE   800
`define VIDEO_HBACK   48
`define VIDEO_HFRONT  16
`define VIDEO_HPULSE  96

// Vertical timing in lines
`define VIDEO_VLINE   449
`define VIDEO_VBACK   35
`define VIDEO_VFRONT  12
`define VIDEO_VPULSE  2

`define VIDEO_POS_WIDTH 11

//==============================
// Framebuffer and bus
//==============================

// 320 pixels per row, four per word
`define FB_PITCH_WORDS 80
`define FB_ADDR_WIDTH  14

// Top address bit selects the palette
`define WB_ADDR_WIDTH  16
`define PALETTE_INDEX_WIDTH 8

`endif

// File: source/video_pkg.sv
`include "video_config.svh"

package video_pkg;

	// One bus word, seen either as pixels or as a palette colour.
	// Byte 0 of pixels is the leftmost pixel on screen.
	typedef union packed {
		logic [3:0][`PALETTE_INDEX_WIDTH-1:0] pixels;
		struct packed {
			// Always reads back as zero
			logic [7:0] unused;
			logic [7:0] blue;
			logic [7:0] green;
			logic [7:0] red;
		} color;
	} video_word_u;

endpackage

// File: source/video_interfaces.sv
`timescale 1ns/100ps

`include "video_config.svh"

// CPU side access to framebuffer and palette
interface vram_access_if;
	import video_pkg::*;

	logic strobe;
	logic write;
	logic palette_sel;
	logic [`WB_ADDR_WIDTH-2:0] address;
	video_word_u wdata;
	video_word_u fb_rdata;
	video_word_u pal_rdata;

	modport bus (
		output strobe, write, palette_sel, address, wdata,
		input fb_rdata, pal_rdata
	);

	modport framebuffer (
		input strobe, write, palette_sel, address, wdata,
		output fb_rdata
	);

	modport palette (
		input strobe, write, palette_sel, address, wdata,
		output pal_rdata
	);
endinterface

// Raw timing from the signal generator
interface scan_if;
	logic hsync;
	logic vsync;
	logic de;
	logic [`VIDEO_POS_WIDTH-1:0] pos_x;
	logic [`VIDEO_POS_WIDTH-1:0] pos_y;

	modport source (output hsync, vsync, de, pos_x, pos_y);
	modport sink (input hsync, vsync, de, pos_x, pos_y);
endinterface

// Palette indices with aligned syncs
interface pixel_if;
	logic hsync;
	logic vsync;
	logic de;
	logic [`PALETTE_INDEX_WIDTH-1:0] index;

	modport source (output hsync, vsync, de, index);
	modport sink (input hsync, vsync, de, index);
endinterface

// File: source/vmode_bus_port.sv
`timescale 1ns/100ps

`include "video_config.svh"

module vmode_bus_port (
	input  logic i_clock,
	input  logic i_reset,

	// Wishbone classic slave
	input  logic i_wb_cyc,
	input  logic i_wb_stb,
	input  logic i_wb_we,
	input  logic [`WB_ADDR_WIDTH-1:0] i_wb_adr,
	input  logic [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic o_wb_ack,

	vram_access_if.bus vram
);

	logic start;
	logic region_q;

	// New cycle seen while ack is low
	assign start = i_wb_cyc && i_wb_stb && !o_wb_ack;

	//==============================
	// Memory side
	//==============================

	assign vram.strobe      = start;
	assign vram.write       = i_wb_we;
	assign vram.palette_sel = i_wb_adr[`WB_ADDR_WIDTH-1];
	assign vram.address     = i_wb_adr[`WB_ADDR_WIDTH-2:0];
	assign vram.wdata       = i_wb_dat;

	//==============================
	// Acknowledge and read data
	//==============================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_wb_ack <= 1'b0;
		end else begin
			o_wb_ack <= start;
		end
	end

	// Remember which memory answers this cycle
	always_ff @(posedge i_clock) begin
		if (start) begin
			region_q <= vram.palette_sel;
		end
	end

	assign o_wb_dat = region_q ? vram.pal_rdata : vram.fb_rdata;

	// One clock ack, never back to back
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb_ack |=> !o_wb_ack)
	else
		$error("vmode_bus_port: ack held for two cycles");

endmodule

// File: source/video_timing.sv
`timescale 1ns/100ps

`include "video_config.svh"

module video_timing (
	input logic i_clock,
	input logic i_reset,

	scan_if.source scan
);

	localparam int pos_w = `VIDEO_POS_WIDTH;

	// Visible area, then front porch, sync and back porch
	localparam logic [pos_w-1:0] h_active =
		pos_w'(`VIDEO_HLINE - `VIDEO_HBACK - `VIDEO_HFRONT - `VIDEO_HPULSE);
	localparam logic [pos_w-1:0] h_sync_start = pos_w'(h_active + `VIDEO_HFRONT);
	localparam logic [pos_w-1:0] h_sync_end = pos_w'(h_sync_start + `VIDEO_HPULSE);
	localparam logic [pos_w-1:0] h_last = pos_w'(`VIDEO_HLINE - 1);

	localparam logic [pos_w-1:0] v_active =
		pos_w'(`VIDEO_VLINE - `VIDEO_VBACK - `VIDEO_VFRONT - `VIDEO_VPULSE);
	localparam logic [pos_w-1:0] v_sync_start = pos_w'(v_active + `VIDEO_VFRONT);
	localparam logic [pos_w-1:0] v_sync_end = pos_w'(v_sync_start + `VIDEO_VPULSE);
	localparam logic [pos_w-1:0] v_last = pos_w'(`VIDEO_VLINE - 1);

	logic [pos_w-1:0] h_count;
	logic [pos_w-1:0] v_count;
	logic h_in_sync;
	logic v_in_sync;
	logic visible;

	//==============================
	// Counters
	//==============================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_count == h_last) begin
			h_count <= '0;
			if (v_count == v_last) begin
				v_count <= '0;
			end else begin
				v_count <= v_count + 1'b1;
			end
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	assign h_in_sync = (h_count >= h_sync_start) && (h_count < h_sync_end);
	assign v_in_sync = (v_count >= v_sync_start) && (v_count < v_sync_end);
	assign visible   = (h_count < h_active) && (v_count < v_active);

	//==============================
	// Registered outputs
	//==============================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			scan.hsync <= 1'b1;
			scan.vsync <= 1'b0;
			scan.de    <= 1'b0;
		end else begin
			// hsync low active, vsync high active for 400 lines
			scan.hsync <= !h_in_sync;
			scan.vsync <= v_in_sync;
			scan.de    <= visible;
		end
	end

	// Position is only meaningful while de is high
	always_ff @(posedge i_clock) begin
		scan.pos_x <= h_count;
		scan.pos_y <= v_count;
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		scan.de |-> (scan.hsync && !scan.vsync))
	else
		$error("video_timing: de active during sync");

endmodule

// File: source/framebuffer.sv
`timescale 1ns/100ps

`include "video_config.svh"

module framebuffer (
	input logic i_clock,

	vram_access_if.framebuffer vram,
	scan_if.sink scan,
	pixel_if.source pixels
);
	import video_pkg::*;

	localparam int depth = 2 ** `FB_ADDR_WIDTH;

	video_word_u mem [0:depth-1];

	logic [`FB_ADDR_WIDTH-1:0] cpu_addr;
	logic cpu_hit;

	logic [`VIDEO_POS_WIDTH-2:0] half_x;
	logic [`VIDEO_POS_WIDTH-2:0] half_y;
	logic [`FB_ADDR_WIDTH-1:0] scan_addr;

	video_word_u scan_word;
	logic [1:0] byte_sel;
	logic hsync_d;
	logic vsync_d;
	logic de_d;

	//==============================
	// CPU port
	//==============================

	assign cpu_addr = vram.address[`FB_ADDR_WIDTH-1:0];
	assign cpu_hit  = vram.strobe && !vram.palette_sel;

	always_ff @(posedge i_clock) begin
		if (cpu_hit) begin
			if (vram.write) begin
				mem[cpu_addr] <= vram.wdata;
			end
			vram.fb_rdata <= mem[cpu_addr];
		end
	end

	//==============================
	// Scan port
	//==============================

	// 320 x 200 shown at double size
	assign half_x = scan.pos_x[`VIDEO_POS_WIDTH-1:1];
	assign half_y = scan.pos_y[`VIDEO_POS_WIDTH-1:1];

	assign scan_addr = `FB_ADDR_WIDTH'(half_y * `FB_PITCH_WORDS + (half_x >> 2));

	// Stage 1, word fetch
	always_ff @(posedge i_clock) begin
		scan_word <= mem[scan_addr];
		byte_sel  <= half_x[1:0];
		hsync_d   <= scan.hsync;
		vsync_d   <= scan.vsync;
		de_d      <= scan.de;
	end

	// Stage 2, pick one of four pixels
	always_ff @(posedge i_clock) begin
		pixels.index <= scan_word.pixels[byte_sel];
		pixels.hsync <= hsync_d;
		pixels.vsync <= vsync_d;
		pixels.de    <= de_d;
	end

endmodule

// File: source/palette_output.sv
`timescale 1ns/100ps

`include "video_config.svh"

module palette_output (
	input  logic i_clock,
	input  logic i_reset,

	vram_access_if.palette vram,
	pixel_if.sink pixels,

	output logic o_hsync,
	output logic o_vsync,
	output logic o_de,
	output logic [7:0] o_red,
	output logic [7:0] o_green,
	output logic [7:0] o_blue
);
	import video_pkg::*;

	localparam int entries = 2 ** `PALETTE_INDEX_WIDTH;

	video_word_u pal [0:entries-1];

	logic [`PALETTE_INDEX_WIDTH-1:0] cpu_index;
	video_word_u wr_word;
	video_word_u lookup;

	//==============================
	// CPU port
	//==============================

	assign cpu_index = vram.address[`PALETTE_INDEX_WIDTH-1:0];

	// Top byte stored as zero
	always_comb begin
		wr_word = vram.wdata;
		wr_word.color.unused = '0;
	end

	always_ff @(posedge i_clock) begin
		if (vram.strobe && vram.palette_sel) begin
			if (vram.write) begin
				pal[cpu_index] <= wr_word;
			end
			vram.pal_rdata <= pal[cpu_index];
		end
	end

	//==============================
	// Colour lookup
	//==============================

	assign lookup = pal[pixels.index];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_hsync <= 1'b1;
			o_vsync <= 1'b0;
			o_de    <= 1'b0;
			o_red   <= '0;
			o_green <= '0;
			o_blue  <= '0;
		end else begin
			o_hsync <= pixels.hsync;
			o_vsync <= pixels.vsync;
			o_de    <= pixels.de;
			// Black outside the visible area
			o_red   <= pixels.de ? lookup.color.red : '0;
			o_green <= pixels.de ? lookup.color.green : '0;
			o_blue  <= pixels.de ? lookup.color.blue : '0;
		end
	end

endmodule

// File: source/video_top.sv
`timescale 1ns/100ps

`include "video_config.svh"

module video_top (
	input  logic i_clock,
	input  logic i_reset,

	// Wishbone slave
	input  logic i_wb_cyc,
	input  logic i_wb_stb,
	input  logic i_wb_we,
	input  logic [`WB_ADDR_WIDTH-1:0] i_wb_adr,
	input  logic [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic o_wb_ack,

	// Video out
	output logic o_hsync,
	output logic o_vsync,
	output logic o_de,
	output logic [7:0] o_red,
	output logic [7:0] o_green,
	output logic [7:0] o_blue
);

	vram_access_if vram();
	scan_if scan();
	pixel_if pixels();

	//==============================
	// CPU access
	//==============================

	vmode_bus_port bus_port (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we  (i_wb_we),
		.i_wb_adr (i_wb_adr),
		.i_wb_dat (i_wb_dat),
		.o_wb_dat (o_wb_dat),
		.o_wb_ack (o_wb_ack),
		.vram     (vram)
	);

	//==============================
	// Video path
	//==============================

	video_timing timing (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.scan    (scan)
	);

	// Two cycles, fetch then byte select
	framebuffer fb (
		.i_clock (i_clock),
		.vram    (vram),
		.scan    (scan),
		.pixels  (pixels)
	);

	palette_output palette (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.vram    (vram),
		.pixels  (pixels),
		.o_hsync (o_hsync),
		.o_vsync (o_vsync),
		.o_de    (o_de),
		.o_red   (o_red),
		.o_green (o_green),
		.o_blue  (o_blue)
	);

endmodule

// File: verification/tb_video_top.sv
`timescale 1ns/100ps

module tb_video_top;

	localparam longint clock_period = 40;
	localparam longint fill_cycles = 3 * (16384 + 256);
	localparam longint watchdog_cycles = (16 + fill_cycles + 3 * 800 * 449) * 3 / 2;

	logic i_clock;
	logic i_reset;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	logic [15:0] i_wb_adr;
	logic [31:0] i_wb_dat;
	logic [31:0] o_wb_dat;
	logic o_wb_ack;
	logic o_hsync;
	logic o_vsync;
	logic o_de;
	logic [7:0] o_red;
	logic [7:0] o_green;
	logic [7:0] o_blue;

	// Reference models of both memories
	logic [31:0] fb_model [0:16383];
	logic [31:0] pal_model [0:255];
	logic [15:0] lfsr_state;
	logic expect_read;
	logic [31:0] expect_rdata;
	logic pixel_check;
	logic [7:0] pal_index;

	int error_count;
	int pixel_errors;
	int tests_run;
	int tests_failed;
	int errors_at_start;
	// Run lengths and event counts on the video outputs
	int hs_len;
	int de_len;
	int vs_len;
	int de_runs;
	int hs_pulses;
	int vs_rises;
	int pix_cnt;

	video_top UUT (.*);

	initial begin
		i_clock = 1'b0;
		forever #(clock_period / 2) i_clock = ~i_clock;
	end

	initial begin
		#(watchdog_cycles * clock_period);
		$display("watchdog: the run did not finish within its time limit");
		$display("Done: errors found");
		$finish;
	end

	//==============================
	// Helpers
	//==============================

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("mismatch at %0t: %s expected 'h%0h got 'h%0h", $time, name, exp_val, act_val);
		error_count++;
	endtask

	task automatic report_failure(input string what);
		$display("error at %0t: %s", $time, what);
		error_count++;
	endtask

	// Polynomial x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	// Expected colour of visible pixel n after vsync at double size
	function automatic logic [23:0] pixel_colour(input int count);
		int fb_x;
		int fb_y;
		logic [13:0] word_addr;
		logic [31:0] word;
		logic [7:0] index;
		fb_x = (count % 640) / 2;
		fb_y = (count / 640) / 2;
		word_addr = 14'(fb_y * 80 + fb_x / 4);
		word = fb_model[word_addr];
		index = 8'(word >> (8 * (fb_x % 4)));
		return pal_model[index][23:0];
	endfunction

	// One Wishbone classic cycle that also updates the models
	task automatic bus_access(input logic we, input logic [15:0] adr, input logic [31:0] dat);
		int waited;
		@(negedge i_clock);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = we;
		i_wb_adr = adr;
		i_wb_dat = dat;
		expect_read = !we;
		expect_rdata = adr[15] ? pal_model[adr[7:0]] : fb_model[adr[13:0]];
		if (we && adr[15]) begin
			pal_model[adr[7:0]] = {8'h00, dat[23:0]};
		end else if (we) begin
			fb_model[adr[13:0]] = dat;
		end
		waited = 0;
		do begin
			@(negedge i_clock);
			waited++;
		end while (!o_wb_ack && waited < 8);
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
	endtask

	// Errors counted since the previous call
	function automatic int take_new_errors();
		int count;
		count = error_count - errors_at_start;
		errors_at_start = error_count;
		return count;
	endfunction

	task automatic finish_test(input string name, input int failures);
		tests_run++;
		if (failures == 0) begin
			$display("test %0d %s: pass", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: fail with %0d errors", tests_run, name, failures);
		end
	endtask

	//==============================
	// Output monitors
	//==============================

	always @(posedge i_clock) begin
		if (i_reset) begin
			hs_len <= 0;
			de_len <= 0;
			vs_len <= 0;
			de_runs <= 0;
			hs_pulses <= 0;
			vs_rises <= 0;
			pix_cnt <= 0;
		end else begin
			hs_len <= o_hsync ? 0 : hs_len + 1;
			de_len <= o_de ? de_len + 1 : 0;
			vs_len <= o_vsync ? vs_len + 1 : 0;
			pix_cnt <= o_vsync ? 0 : (o_de ? pix_cnt + 1 : pix_cnt);
			if (o_vsync && vs_len == 0) begin
				de_runs <= 0;
				hs_pulses <= 0;
				vs_rises <= vs_rises + 1;
			end else begin
				de_runs <= (o_de && de_len == 0) ? de_runs + 1 : de_runs;
				hs_pulses <= (!o_hsync && hs_len == 0) ? hs_pulses + 1 : hs_pulses;
			end
		end
	end

	assert property (@(posedge i_clock) $fell(i_reset) |->
		{o_wb_ack, o_de, o_hsync, o_vsync, o_red, o_green, o_blue} == {4'b0010, 24'h0})
	else
		report_mismatch("ack,de,hsync,vsync,rgb after reset", {4'h0, 4'b0010, 24'h0},
			{4'h0, $sampled({o_wb_ack, o_de, o_hsync, o_vsync, o_red, o_green, o_blue})});

	assert property (@(posedge i_clock) disable iff (i_reset)
		i_wb_cyc && i_wb_stb && !o_wb_ack |=> o_wb_ack)
	else
		report_failure("o_wb_ack did not follow the sampled strobe after one cycle");

	assert property (@(posedge i_clock) disable iff (i_reset) o_wb_ack |=> !o_wb_ack)
	else
		report_failure("o_wb_ack stayed high for more than one cycle");

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb_ack && expect_read |-> o_wb_dat == expect_rdata)
	else
		report_mismatch("o_wb_dat", $sampled(expect_rdata), $sampled(o_wb_dat));

	assert property (@(posedge i_clock) disable iff (i_reset) $rose(o_hsync) |-> hs_len == 96)
	else
		report_mismatch("o_hsync low clocks", 32'd96, $sampled(hs_len));

	assert property (@(posedge i_clock) disable iff (i_reset) $fell(o_de) |-> de_len == 640)
	else
		report_mismatch("o_de run clocks", 32'd640, $sampled(de_len));

	assert property (@(posedge i_clock) disable iff (i_reset) $rose(o_vsync) |-> de_runs == 400)
	else
		report_mismatch("o_de runs per frame", 32'd400, $sampled(de_runs));

	// The first period after reset is partial
	assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_vsync) && vs_rises > 0 |-> hs_pulses == 449)
	else
		report_mismatch("o_hsync pulses per frame", 32'd449, $sampled(hs_pulses));

	assert property (@(posedge i_clock) disable iff (i_reset) $fell(o_vsync) |-> vs_len == 1600)
	else
		report_mismatch("o_vsync high clocks", 32'd1600, $sampled(vs_len));

	assert property (@(posedge i_clock) disable iff (i_reset || !pixel_check)
		o_de |-> {o_blue, o_green, o_red} == pixel_colour(pix_cnt))
	else begin
		pixel_errors++;
		report_mismatch("rgb", {8'h00, pixel_colour($sampled(pix_cnt))},
			{8'h00, $sampled(o_blue), $sampled(o_green), $sampled(o_red)});
	end

	//==============================
	// Stimulus
	//==============================

	initial begin
		i_reset = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		expect_read = 1'b0;
		expect_rdata = '0;
		pixel_check = 1'b0;
		lfsr_state = 16'd36983;
		error_count = 0;
		pixel_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		errors_at_start = 0;

		repeat (16) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;
		repeat (2) @(negedge i_clock);
		finish_test("reset values", take_new_errors());

		repeat (16) begin
			i_wb_adr = {2'b00, 14'(rand_bits(14))};
			bus_access(1'b1, i_wb_adr, rand_bits(32));
			bus_access(1'b0, i_wb_adr, 32'h0);
		end
		finish_test("framebuffer write and read", take_new_errors());

		repeat (16) begin
			pal_index = 8'(rand_bits(8));
			bus_access(1'b1, {8'h80, pal_index}, rand_bits(32));
			bus_access(1'b0, {8'h80, pal_index}, 32'h0);
		end
		finish_test("palette write and read", take_new_errors());

		// Fill both memories and check one whole frame
		for (int a = 0; a < 16384; a++) begin
			bus_access(1'b1, 16'(a), rand_bits(32));
		end
		for (int a = 0; a < 256; a++) begin
			bus_access(1'b1, 16'h8000 | 16'(a), rand_bits(32));
		end
		@(posedge o_vsync);
		@(negedge i_clock);
		pixel_check = 1'b1;
		@(posedge o_vsync);
		@(negedge i_clock);
		pixel_check = 1'b0;
		finish_test("frame structure", take_new_errors() - pixel_errors);
		finish_test("pixels from framebuffer and palette", pixel_errors);

		// Palette changes in the middle of a visible line
		while (!o_de) @(negedge i_clock);
		repeat (8) begin
			pal_index = 8'(rand_bits(8));
			bus_access(1'b1, {8'h80, pal_index}, rand_bits(32));
		end
		@(posedge o_vsync);
		@(negedge i_clock);
		pixel_check = 1'b1;
		@(posedge o_vsync);
		@(negedge i_clock);
		pixel_check = 1'b0;
		finish_test("palette writes during active video", take_new_errors());

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+source
source/video_pkg.sv
source/video_interfaces.sv
source/vmode_bus_port.sv
source/video_timing.sv
source/framebuffer.sv
source/palette_output.sv
source/video_top.sv
verification/tb_video_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the video testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f \
	--top-module tb_video_top --Mdir obj_dir -o sim_video; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_video > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" sim.log; then
	echo "simulation reported errors"
	exit 1
fi

echo "simulation passed"
exit 0
